// ==== hdl/rvIsaPkg.sv ====
package rvIsaPkg;

	localparam int XLEN = 32;

	// Major opcodes kept in this core
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcodeE;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB // LUI
	} aluOpE;

	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branchF3E;

	// funct3 of OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000; // also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by funct7
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// ==== hdl/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEMORY,
		ST_WRITEBACK,
		ST_HALTED
	} ctrlStateE;

	typedef enum logic {
		SRCA_PC,
		SRCA_RS1
	} srcASelE;

	typedef enum logic {
		SRCB_RS2,
		SRCB_IMM
	} srcBSelE;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4 // link address
	} wbSelE;

	localparam int MEM_AW = 12;

	// addi x1, x0, 12 followed by jalr x0, 0(x1)
	localparam logic [31:0] HALT_PREV = 32'h00c00093;
	localparam logic [31:0] HALT_LAST = 32'h00008067;

endpackage

// ==== hdl/decodeIf.sv ====
interface decodeIf import rvIsaPkg::*, cpuCtrlPkg::*; ();

	opcodeE opcode;
	aluOpE aluOp;
	logic [2:0] funct3;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [XLEN-1:0] imm;
	srcASelE srcASel;
	srcBSelE srcBSel;
	wbSelE wbSel;
	logic regWriteEn;
	logic isBranch;

	modport decode (
		output opcode, aluOp, funct3, rs1, rs2, rd, imm,
		output srcASel, srcBSel, wbSel, regWriteEn, isBranch
	);

	modport exec (
		input aluOp, funct3, imm, srcASel, srcBSel, isBranch
	);

	modport result (
		input rd, wbSel, regWriteEn
	);

endinterface

// ==== hdl/instrDecode.sv ====
module instrDecode import rvIsaPkg::*, cpuCtrlPkg::*; (
	input logic CLK,
	input logic rst,
	input logic irLoad,
	input logic [XLEN-1:0] iMemData,
	decodeIf.decode dec
);

	logic [XLEN-1:0] ir;
	opcodeE opcode;
	logic [2:0] funct3;
	logic altOp; // funct7 bit 5

	always_ff @(posedge CLK) begin
		if (rst)
			ir <= '0;
		else if (irLoad)
			ir <= iMemData;
	end

	assign opcode = opcodeE'(ir[6:0]);
	assign funct3 = ir[14:12];
	assign altOp = ir[30];

	assign dec.opcode = opcode;
	assign dec.funct3 = funct3;
	assign dec.rd = ir[11:7];
	assign dec.rs1 = ir[19:15];
	assign dec.rs2 = ir[24:20];
	assign dec.isBranch = (opcode == OPC_BRANCH);

	// Immediate by instruction format
	always_comb begin
		case (opcode)
			OPC_STORE:
				dec.imm = {{(XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
			OPC_BRANCH:
				dec.imm = {{(XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:
				dec.imm = {ir[31:12], 12'b0};
			OPC_JAL:
				dec.imm = {{(XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			default:
				dec.imm = {{(XLEN-12){ir[31]}}, ir[31:20]}; // I-type
		endcase
	end

	always_comb begin
		dec.aluOp = ALU_ADD; // address and target math
		dec.srcASel = SRCA_RS1;
		dec.srcBSel = SRCB_IMM;
		dec.wbSel = WB_ALU;
		dec.regWriteEn = 1'b1;
		case (opcode)
			OPC_LUI: dec.aluOp = ALU_PASSB;
			OPC_AUIPC: dec.srcASel = SRCA_PC;
			OPC_JAL: begin
				dec.srcASel = SRCA_PC;
				dec.wbSel = WB_PC4;
			end
			OPC_JALR: dec.wbSel = WB_PC4;
			OPC_BRANCH: begin
				dec.srcASel = SRCA_PC;
				dec.regWriteEn = 1'b0;
			end
			OPC_LOAD: dec.wbSel = WB_MEM;
			OPC_STORE: dec.regWriteEn = 1'b0;
			OPC_OPIMM, OPC_OP: begin
				if (opcode == OPC_OP)
					dec.srcBSel = SRCB_RS2;
				case (funct3)
					F3_ADD: dec.aluOp = (opcode == OPC_OP && altOp) ? ALU_SUB : ALU_ADD;
					F3_SLL: dec.aluOp = ALU_SLL;
					F3_SLT: dec.aluOp = ALU_SLT;
					F3_SLTU: dec.aluOp = ALU_SLTU;
					F3_XOR: dec.aluOp = ALU_XOR;
					F3_SR: dec.aluOp = altOp ? ALU_SRA : ALU_SRL;
					F3_OR: dec.aluOp = ALU_OR;
					F3_AND: dec.aluOp = ALU_AND;
					default: dec.aluOp = ALU_ADD;
				endcase
			end
			default: dec.regWriteEn = 1'b0; // Unknown opcode writes nothing
		endcase
	end

endmodule

// ==== hdl/cycleControl.sv ====
module cycleControl import rvIsaPkg::*, cpuCtrlPkg::*; (
	input logic CLK,
	input logic rst,
	input opcodeE opcode,
	input logic [XLEN-1:0] instrWord,
	input logic [XLEN-1:0] aluResult,
	input logic branchTaken,
	output logic irLoad,
	output logic aluLoad,
	output logic regWrite,
	output logic dMemWen,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] numInst,
	output logic halt
);

	ctrlStateE state;
	ctrlStateE nextState;
	logic pcLoad;
	logic instDone;
	logic haltPending;
	logic [XLEN-1:0] prevWord;
	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] branchOffset;
	logic [XLEN-1:0] nextPc;

	assign pcPlus4 = pc + XLEN'(4);
	assign branchOffset = {{(XLEN-12){instrWord[31]}}, instrWord[7], instrWord[30:25],
		instrWord[11:8], 1'b0};

	always_comb begin
		nextState = state;
		irLoad = 1'b0;
		aluLoad = 1'b0;
		regWrite = 1'b0;
		dMemWen = 1'b0;
		pcLoad = 1'b0;
		instDone = 1'b0;
		case (state)
			ST_FETCH: begin
				irLoad = 1'b1;
				nextState = ST_DECODE;
			end
			ST_DECODE: nextState = ST_EXECUTE;
			ST_EXECUTE: begin
				aluLoad = 1'b1;
				if (opcode == OPC_BRANCH) begin
					pcLoad = 1'b1;
					instDone = 1'b1;
					nextState = ST_FETCH;
				end else if (opcode == OPC_STORE) begin
					pcLoad = 1'b1; // pc moves on before the write
					nextState = ST_MEMORY;
				end else if (opcode == OPC_LOAD)
					nextState = ST_MEMORY;
				else
					nextState = ST_WRITEBACK;
			end
			ST_MEMORY: begin
				if (opcode == OPC_STORE) begin
					dMemWen = 1'b1;
					instDone = 1'b1;
					nextState = ST_FETCH;
				end else
					nextState = ST_WRITEBACK;
			end
			ST_WRITEBACK: begin
				regWrite = 1'b1;
				pcLoad = 1'b1;
				instDone = 1'b1;
				nextState = ST_FETCH;
			end
			default: nextState = state; // Halted for good
		endcase
		if (instDone && haltPending)
			nextState = ST_HALTED;
	end

	always_comb begin
		if (opcode == OPC_BRANCH)
			nextPc = branchTaken ? pc + branchOffset : pcPlus4;
		else if (opcode == OPC_JAL)
			nextPc = aluResult;
		else if (opcode == OPC_JALR)
			nextPc = {aluResult[XLEN-1:1], 1'b0};
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= ST_FETCH;
			pc <= '0;
			numInst <= '0;
			halt <= 1'b0;
			prevWord <= '0;
			haltPending <= 1'b0;
		end else begin
			state <= nextState;
			if (pcLoad)
				pc <= nextPc;
			// instrWord still matches pc here, every instruction completes after execute
			if (aluLoad) begin
				prevWord <= instrWord;
				haltPending <= (prevWord == HALT_PREV) && (instrWord == HALT_LAST);
			end
			if (instDone) begin
				numInst <= numInst + XLEN'(1);
				halt <= haltPending;
			end
		end
	end

endmodule

// ==== hdl/aluExecute.sv ====
module aluExecute import rvIsaPkg::*, cpuCtrlPkg::*; (
	input logic CLK,
	input logic rst,
	input logic aluLoad,
	decodeIf.exec ex,
	input logic [XLEN-1:0] pc,
	input logic [XLEN-1:0] rs1Data,
	input logic [XLEN-1:0] rs2Data,
	output logic [XLEN-1:0] aluResult,
	output logic branchTaken
);

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluOut;
	logic cond;

	assign opA = (ex.srcASel == SRCA_PC) ? pc : rs1Data;
	assign opB = (ex.srcBSel == SRCB_IMM) ? ex.imm : rs2Data;

	always_comb begin
		case (ex.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_SLL: aluOut = opA << opB[4:0];
			ALU_SLT: aluOut = XLEN'($signed(opA) < $signed(opB));
			ALU_SLTU: aluOut = XLEN'(opA < opB);
			ALU_XOR: aluOut = opA ^ opB;
			ALU_SRL: aluOut = opA >> opB[4:0];
			ALU_SRA: aluOut = $unsigned($signed(opA) >>> opB[4:0]);
			ALU_OR: aluOut = opA | opB;
			ALU_AND: aluOut = opA & opB;
			ALU_PASSB: aluOut = opB;
			default: aluOut = '0;
		endcase
	end

	// Memory address and jump target for the later states
	always_ff @(posedge CLK) begin
		if (rst)
			aluResult <= '0;
		else if (aluLoad)
			aluResult <= aluOut;
	end

	// Compare always works on the register operands
	always_comb begin
		case (branchF3E'(ex.funct3))
			BR_EQ: cond = (rs1Data == rs2Data);
			BR_NE: cond = (rs1Data != rs2Data);
			BR_LT: cond = ($signed(rs1Data) < $signed(rs2Data));
			BR_GE: cond = ($signed(rs1Data) >= $signed(rs2Data));
			BR_LTU: cond = (rs1Data < rs2Data);
			BR_GEU: cond = (rs1Data >= rs2Data);
			default: cond = 1'b0;
		endcase
	end

	assign branchTaken = ex.isBranch && cond;

endmodule

// ==== hdl/resultWrite.sv ====
module resultWrite import rvIsaPkg::*, cpuCtrlPkg::*; (
	input logic CLK,
	input logic rst,
	input logic regWrite,
	decodeIf.result res,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [XLEN-1:0] aluResult,
	input logic [XLEN-1:0] dMemRdata,
	input logic [XLEN-1:0] pc,
	input logic isBranch,
	input logic branchTaken,
	output logic [XLEN-1:0] rs1Data,
	output logic [XLEN-1:0] rs2Data,
	output logic [XLEN-1:0] outputPort
);

	logic [XLEN-1:0] regs [32];
	logic [XLEN-1:0] wrData;

	always_comb begin
		case (res.wbSel)
			WB_MEM: wrData = dMemRdata;
			WB_PC4: wrData = pc + XLEN'(4); // pc not yet updated in writeback
			default: wrData = aluResult;
		endcase
	end

	// x0 is hardwired
	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge CLK) begin
		if (regWrite && res.regWriteEn)
			regs[res.rd] <= wrData;
	end

	always_ff @(posedge CLK) begin
		if (rst)
			outputPort <= '0;
		else if (regWrite)
			outputPort <= wrData;
		else if (isBranch)
			outputPort <= {{(XLEN-1){1'b0}}, branchTaken}; // Branch outcome
	end

endmodule

// ==== hdl/riscvTop.sv ====
module riscvTop import rvIsaPkg::*, cpuCtrlPkg::*; (
	input logic CLK,
	input logic rst,
	input logic [XLEN-1:0] iMemData,
	output logic [MEM_AW-1:0] iMemAddr, // byte address
	input logic [XLEN-1:0] dMemRdata,
	output logic [MEM_AW-1:0] dMemAddr, // word address
	output logic [XLEN-1:0] dMemWdata,
	output logic dMemWen,
	output logic halt,
	output logic [XLEN-1:0] numInst,
	output logic [XLEN-1:0] outputPort
);

	logic irLoad;
	logic aluLoad;
	logic regWrite;
	logic branchTaken;
	logic branchDone;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;

	decodeIf dec();

	assign iMemAddr = pc[MEM_AW-1:0];
	assign dMemAddr = aluResult[MEM_AW+1:2];
	assign dMemWdata = rs2Data;
	assign branchDone = aluLoad & dec.isBranch; // Branches complete in execute

	instrDecode i_instrDecode (
		.CLK      (CLK),
		.rst      (rst),
		.irLoad   (irLoad),
		.iMemData (iMemData),
		.dec      (dec)
	);

	// iMemData still holds the current word until pc moves
	cycleControl i_cycleControl (
		.CLK         (CLK),
		.rst         (rst),
		.opcode      (dec.opcode),
		.instrWord   (iMemData),
		.aluResult   (aluResult),
		.branchTaken (branchTaken),
		.irLoad      (irLoad),
		.aluLoad     (aluLoad),
		.regWrite    (regWrite),
		.dMemWen     (dMemWen),
		.pc          (pc),
		.numInst     (numInst),
		.halt        (halt)
	);

	aluExecute i_aluExecute (
		.CLK         (CLK),
		.rst         (rst),
		.aluLoad     (aluLoad),
		.ex          (dec),
		.pc          (pc),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data),
		.aluResult   (aluResult),
		.branchTaken (branchTaken)
	);

	resultWrite i_resultWrite (
		.CLK         (CLK),
		.rst         (rst),
		.regWrite    (regWrite),
		.res         (dec),
		.rs1         (dec.rs1),
		.rs2         (dec.rs2),
		.aluResult   (aluResult),
		.dMemRdata   (dMemRdata),
		.pc          (pc),
		.isBranch    (branchDone),
		.branchTaken (branchTaken),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data),
		.outputPort  (outputPort)
	);

endmodule

// ==== tests/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Major opcodes as listed in the ISA manual
localparam logic [6:0] OP_LUI = 7'b0110111;
localparam logic [6:0] OP_AUIPC = 7'b0010111;
localparam logic [6:0] OP_JAL = 7'b1101111;
localparam logic [6:0] OP_JALR = 7'b1100111;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_LOAD = 7'b0000011;
localparam logic [6:0] OP_STORE = 7'b0100011;
localparam logic [6:0] OP_IMM = 7'b0010011;
localparam logic [6:0] OP_REG = 7'b0110011;

function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// Columns: instruction word, skipped flag, expected outputPort
task automatic buildProgram();
	addRow(encI(12'h7ff, 5'd0, 3'b000, 5'd2, OP_IMM), 1'b0, 32'h000007ff); // 0x00
	addRow(encI(12'h800, 5'd0, 3'b000, 5'd3, OP_IMM), 1'b0, 32'hfffff800);
	addRow(encU(20'h80000, 5'd4, OP_LUI), 1'b0, 32'h80000000);
	addRow(encU(20'h00001, 5'd5, OP_AUIPC), 1'b0, 32'h0000100c); // pc 0x0c
	addRow(encI(12'hfff, 5'd0, 3'b000, 5'd6, OP_IMM), 1'b0, 32'hffffffff);
	addRow(encR(7'h20, 5'd2, 5'd4, 3'b000, 5'd7), 1'b0, 32'h7ffff801); // sub
	addRow(encI(12'd35, 5'd0, 3'b000, 5'd9, OP_IMM), 1'b0, 32'h00000023);
	addRow(encR(7'h20, 5'd9, 5'd4, 3'b101, 5'd8), 1'b0, 32'hf0000000); // sra by 3
	addRow(encR(7'h00, 5'd9, 5'd4, 3'b101, 5'd10), 1'b0, 32'h10000000);
	addRow(encR(7'h00, 5'd2, 5'd4, 3'b010, 5'd11), 1'b0, 32'h00000001); // slt
	addRow(encR(7'h00, 5'd2, 5'd4, 3'b011, 5'd12), 1'b0, 32'h00000000); // sltu
	addRow(encR(7'h00, 5'd9, 5'd6, 3'b001, 5'd13), 1'b0, 32'hfffffff8);
	addRow(encR(7'h00, 5'd6, 5'd3, 3'b100, 5'd14), 1'b0, 32'h000007ff);
	addRow(encR(7'h00, 5'd2, 5'd3, 3'b110, 5'd15), 1'b0, 32'hffffffff);
	addRow(encR(7'h00, 5'd5, 5'd6, 3'b111, 5'd16), 1'b0, 32'h0000100c);
	addRow(encS(12'd64, 5'd4, 5'd0), 1'b0, 32'h0000100c); // Store keeps outputPort
	addRow(encI(12'd64, 5'd0, 3'b010, 5'd17, OP_LOAD), 1'b0, 32'h80000000);
	addRow(encI(12'd128, 5'd0, 3'b010, 5'd18, OP_LOAD), 1'b0, dataPreset[32]);
	addRow(encB(13'd8, 5'd2, 5'd2, 3'b000), 1'b0, 32'h00000001); // beq taken
	addRow(encI(12'h111, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encB(13'd8, 5'd2, 5'd2, 3'b001), 1'b0, 32'h00000000);
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b100), 1'b0, 32'h00000001); // blt taken
	addRow(encI(12'h222, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b101), 1'b0, 32'h00000000);
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b110), 1'b0, 32'h00000000);
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b111), 1'b0, 32'h00000001); // bgeu taken
	addRow(encI(12'h333, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encJ(21'd8, 5'd20), 1'b0, 32'h00000070); // jal from 0x6c
	addRow(encI(12'h444, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encI(12'd132, 5'd0, 3'b000, 5'd21, OP_IMM), 1'b0, 32'h00000084);
	addRow(encI(12'd4, 5'd21, 3'b000, 5'd22, OP_JALR), 1'b0, 32'h0000007c); // to 0x88
	addRow(encI(12'h555, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encI(12'h666, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encI(12'h777, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encI(12'd5, 5'd0, 3'b000, 5'd0, OP_IMM), 1'b0, 32'h00000005); // x0 write
	addRow(encR(7'h00, 5'd2, 5'd0, 3'b000, 5'd23), 1'b0, 32'h000007ff);
	// Each branch kind again with the opposite outcome
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b000), 1'b0, 32'h00000000); // pc 0x90
	addRow(encB(13'd8, 5'd2, 5'd4, 3'b001), 1'b0, 32'h00000001);
	addRow(encI(12'h888, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encB(13'd8, 5'd4, 5'd2, 3'b100), 1'b0, 32'h00000000);
	addRow(encB(13'd8, 5'd4, 5'd2, 3'b101), 1'b0, 32'h00000001); // bge taken
	addRow(encI(12'h999, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encB(13'd8, 5'd4, 5'd2, 3'b110), 1'b0, 32'h00000001);
	addRow(encI(12'haaa, 5'd0, 3'b000, 5'd19, OP_IMM), 1'b1, 32'h00000000);
	addRow(encB(13'd8, 5'd4, 5'd2, 3'b111), 1'b0, 32'h00000000);
	addRow(encI(12'd12, 5'd0, 3'b000, 5'd1, OP_IMM), 1'b0, 32'h0000000c);
	addRow(encI(12'd0, 5'd1, 3'b000, 5'd0, OP_JALR), 1'b0, 32'h000000bc); // Halt pair
endtask

`endif

// ==== tests/riscvTopTb.sv ====
module riscvTopTb import rvIsaPkg::*, cpuCtrlPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic CLK;
	logic rst;
	logic [XLEN-1:0] iMemData;
	logic [MEM_AW-1:0] iMemAddr;
	logic [XLEN-1:0] dMemRdata;
	logic [MEM_AW-1:0] dMemAddr;
	logic [XLEN-1:0] dMemWdata;
	logic dMemWen;
	logic halt;
	logic [XLEN-1:0] numInst;
	logic [XLEN-1:0] outputPort;

	logic [XLEN-1:0] imem [1024];
	logic [XLEN-1:0] dmem [1024];
	logic [XLEN-1:0] dataPreset [1024];
	logic [XLEN-1:0] progWord [$];
	logic progSkip [$];
	logic [XLEN-1:0] progWant [$];
	logic [XLEN-1:0] lastCount;
	logic [XLEN-1:0] doneCount;
	int seed;
	int cycles;
	int cycleLimit;
	int passes;
	int errors;
	int errBefore;
	int r;

	task automatic addRow(input logic [XLEN-1:0] word, input logic skip,
			input logic [XLEN-1:0] want);
		progWord.push_back(word);
		progSkip.push_back(skip);
		progWant.push_back(want);
	endtask

	task automatic checkWord(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			errors++;
		end else
			passes++;
	endtask

	task automatic checkCount(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			errors++;
		end else
			passes++;
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			errors++;
		end else
			passes++;
	endtask

	`include "tbProgram.svh"

	// Both memories answer in the same cycle
	assign iMemData = imem[iMemAddr[MEM_AW-1:2]];
	assign dMemRdata = dmem[dMemAddr[9:0]];

	always @(posedge CLK) begin
		if (dMemWen)
			dmem[dMemAddr[9:0]] <= dMemWdata;
	end

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	riscvTop i_riscvTop (
		.CLK        (CLK),
		.rst        (rst),
		.iMemData   (iMemData),
		.iMemAddr   (iMemAddr),
		.dMemRdata  (dMemRdata),
		.dMemAddr   (dMemAddr),
		.dMemWdata  (dMemWdata),
		.dMemWen    (dMemWen),
		.halt       (halt),
		.numInst    (numInst),
		.outputPort (outputPort)
	);

	initial begin
		@(posedge CLK);
		while (cycles < cycleLimit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: the program did not finish within %0d cycles", cycleLimit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		passes = 0;
		errors = 0;
		cycles = 0;
		seed = 32'h6cc7;
		for (r = 0; r < 1024; r++) begin
			dmem[r] = $random(seed);
			dataPreset[r] = dmem[r];
			imem[r] = encI(12'(r), 5'd0, 3'b000, 5'd0, OP_IMM); // Nop carrying its index
		end
		buildProgram();
		for (r = 0; r < progWord.size(); r++)
			imem[r] = progWord[r];
		cycleLimit = progWord.size() * 6 + 20;

		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		lastCount = '0;
		doneCount = '0;

		for (r = 0; r < progWord.size(); r++) begin
			if (progSkip[r]) begin
				$display("row %2d  pc 0x%03h  skipped", r, r * 4);
				continue;
			end
			while (numInst == lastCount)
				@(negedge CLK);
			errBefore = errors;
			doneCount = doneCount + 1;
			checkWord("outputPort", outputPort, progWant[r]);
			checkCount("numInst", numInst, doneCount);
			lastCount = numInst;
			$display("row %2d  pc 0x%03h  outputPort 0x%08h  numInst %0d  %s", r, r * 4,
				outputPort, numInst, (errors == errBefore) ? "ok" : "wrong");
		end

		// Counter must hold once halted
		repeat (8) @(negedge CLK);
		checkFlag("halt", halt, 1'b1);
		checkCount("numInst", numInst, doneCount);

		$display("Checks: %0d passed, %0d errors", passes, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== riscvTop.f ====
+incdir+tests
hdl/rvIsaPkg.sv
hdl/cpuCtrlPkg.sv
hdl/decodeIf.sv
hdl/instrDecode.sv
hdl/cycleControl.sv
hdl/aluExecute.sv
hdl/resultWrite.sv
hdl/riscvTop.sv
tests/riscvTopTb.sv

// ==== Makefile ====
TOP = riscvTopTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f riscvTop.f --top-module riscvTop

sim:
	verilator --binary --timing -f riscvTop.f --top-module $(TOP) -o riscvTopSim
	./obj_dir/riscvTopSim > sim.log
	cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
